/* src/chroni_pkg.sv */
package chroni_pkg;

   localparam int vram_addr_w     = 17;
   localparam int vram_size       = 131072;
   localparam int chars_per_line  = 40;
   localparam int char_idx_w      = 6;
   localparam int scan_rows       = 8;
   localparam int scan_w          = 3;
   localparam int pixels_per_char = 8;
   localparam int color_w         = 16;
   localparam int pal_idx_w       = 8;

   // cpu register window, 16 bytes
   localparam logic [15:0] reg_base      = 16'h9000;
   localparam logic [3:0]  reg_dl_lo     = 4'd0;    // dl address bits 8:1
   localparam logic [3:0]  reg_dl_hi     = 4'd1;    // dl address bits 16:9
   localparam logic [3:0]  reg_pal_index = 4'd4;
   localparam logic [3:0]  reg_pal_data  = 4'd5;    // low byte then high byte
   localparam logic [3:0]  reg_vaddr_lo  = 4'd6;
   localparam logic [3:0]  reg_vaddr_mid = 4'd7;
   localparam logic [3:0]  reg_vaddr_hi  = 4'd8;
   localparam logic [3:0]  reg_vdata     = 4'd9;

   localparam int          dl_lms_bit  = 6;
   localparam logic [3:0]  dl_end_code = 4'd1;
   localparam int          lms_bytes   = 6;      // text addr then attr addr, 3 bytes each

   typedef logic [vram_addr_w-1:0] vram_addr_t;
   typedef logic [color_w-1:0]     color_t;

   typedef enum logic [2:0] {
      dl_idle, dl_read, dl_read_wait, dl_lms_read, dl_exec
   } dl_state_t;

   typedef enum logic [2:0] {
      fd_idle, fd_text_read, fd_attr_read, fd_font_read, fd_font_fetch, fd_font_wait,
      fd_font_write
   } fetch_state_t;

endpackage

/* src/chroni_regs.sv */
`timescale 1ns/1ps

module chroni_regs (
   input  logic                               sys_clk,
   input  logic                               rst,
   input  logic [15:0]                        cpu_addr,
   input  logic [7:0]                         cpu_wr_data,
   input  logic                               cpu_wr_en,
   output chroni_pkg::vram_addr_t             dl_base,
   output logic                               vram_wr_en,
   output chroni_pkg::vram_addr_t             vram_wr_addr,
   output logic [7:0]                         vram_wr_data,
   output logic                               pal_wr_en,
   output logic [chroni_pkg::pal_idx_w-1:0]   pal_wr_addr,
   output chroni_pkg::color_t                 pal_wr_data
);

   logic                             reg_wr;
   logic                             pal_hi;     // next data byte is the high half
   logic                             pal_pend;   // full pair waiting to be written
   logic [chroni_pkg::pal_idx_w-1:0] pal_index;
   chroni_pkg::color_t               pal_value;
   chroni_pkg::vram_addr_t           port_addr;

   assign reg_wr = cpu_wr_en && cpu_addr[15:4] == chroni_pkg::reg_base[15:4];

   always_ff @(posedge sys_clk) begin
      vram_wr_en <= 1'b0;
      pal_wr_en  <= 1'b0;
      if (rst) begin
         dl_base   <= '0;
         port_addr <= '0;
         pal_index <= '0;
         pal_hi    <= 1'b0;
         pal_pend  <= 1'b0;
      end else if (reg_wr) begin
         case (cpu_addr[3:0])
            chroni_pkg::reg_dl_lo:     dl_base[8:1]    <= cpu_wr_data;
            chroni_pkg::reg_dl_hi:     dl_base[16:9]   <= cpu_wr_data;
            chroni_pkg::reg_pal_index: begin
               pal_index <= cpu_wr_data;
               pal_hi    <= 1'b0;
            end
            chroni_pkg::reg_pal_data: begin
               if (!pal_hi) begin
                  pal_value[7:0] <= cpu_wr_data;
                  pal_hi         <= 1'b1;
               end else begin
                  pal_value[15:8] <= cpu_wr_data;
                  pal_hi          <= 1'b0;
                  pal_pend        <= 1'b1;
               end
            end
            chroni_pkg::reg_vaddr_lo:  port_addr[7:0]  <= cpu_wr_data;
            chroni_pkg::reg_vaddr_mid: port_addr[15:8] <= cpu_wr_data;
            chroni_pkg::reg_vaddr_hi:  port_addr[16]   <= cpu_wr_data[0];
            chroni_pkg::reg_vdata: begin
               vram_wr_en   <= 1'b1;
               vram_wr_addr <= port_addr;
               vram_wr_data <= cpu_wr_data;
               port_addr    <= port_addr + 1'b1;
            end
            default: ;
         endcase
      end else if (pal_pend) begin
         // commit on a quiet cpu cycle
         pal_wr_en   <= 1'b1;
         pal_wr_addr <= pal_index;
         pal_wr_data <= pal_value;
         pal_index   <= pal_index + 1'b1;
         pal_pend    <= 1'b0;
      end
   end

   // a pending pair would be overwritten or land at the wrong index
   a_pal_pair_overrun: assert property (@(posedge sys_clk) disable iff (rst)
      pal_pend && reg_wr |-> cpu_addr[3:0] != chroni_pkg::reg_pal_data &&
                             cpu_addr[3:0] != chroni_pkg::reg_pal_index)
      else $error("palette register written before the previous pair was committed");

endmodule

/* src/chroni_vram.sv */
`timescale 1ns/1ps

module chroni_vram (
   input  logic                   sys_clk,
   input  logic                   wr_en,
   input  chroni_pkg::vram_addr_t wr_addr,
   input  logic [7:0]             wr_data,
   input  chroni_pkg::vram_addr_t rd_addr,
   output logic [7:0]             rd_data
);

   logic [7:0] mem [chroni_pkg::vram_size];

   // cpu side writes, engine side reads
   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

/* src/chroni_spram.sv */
`timescale 1ns/1ps

module chroni_spram #(
   parameter int  depth  = 64,
   parameter type data_t = logic [7:0]
) (
   input  logic                     sys_clk,
   input  logic [$clog2(depth)-1:0] addr,
   input  logic                     we,
   input  data_t                    wr_data,
   output data_t                    rd_data
);

   data_t mem [depth];

   always_ff @(posedge sys_clk) begin
      if (we) begin
         mem[addr] <= wr_data;
      end
      rd_data <= mem[addr];   // old data on a write cycle
   end

endmodule

/* src/chroni_dlist.sv */
`timescale 1ns/1ps

module chroni_dlist (
   input  logic                            sys_clk,
   input  logic                            rst,
   input  logic                            frame_start,
   input  logic                            scanline_start,
   input  chroni_pkg::vram_addr_t          dl_base,
   input  logic [7:0]                      rd_data,
   output logic                            dl_rd,
   output chroni_pkg::vram_addr_t          dl_addr,
   output logic                            row_start,
   output logic                            line_start,
   output logic                            lms_load,
   output chroni_pkg::vram_addr_t          text_base,
   output chroni_pkg::vram_addr_t          attr_base,
   output logic [chroni_pkg::scan_w-1:0]   scan
);

   chroni_pkg::dl_state_t  state;
   chroni_pkg::vram_addr_t ptr;
   logic                   mem_wait;
   logic [2:0]             addr_part;
   logic                   lms_pend;
   logic                   row_active;
   logic                   ended;

   always_ff @(posedge sys_clk) begin
      row_start  <= 1'b0;
      line_start <= 1'b0;
      lms_load   <= 1'b0;
      if (rst || frame_start) begin
         ptr        <= dl_base;
         state      <= chroni_pkg::dl_idle;
         dl_rd      <= 1'b0;
         row_active <= 1'b0;
         ended      <= 1'b0;
         lms_pend   <= 1'b0;
         scan       <= '0;
      end else begin
         case (state)
            chroni_pkg::dl_idle: begin
               if (scanline_start) begin
                  if (row_active && scan != chroni_pkg::scan_w'(chroni_pkg::scan_rows - 1)) begin
                     scan       <= scan + 1'b1;
                     line_start <= 1'b1;
                  end else if (!ended) begin
                     state <= chroni_pkg::dl_read;
                  end
               end
            end
            chroni_pkg::dl_read: begin
               dl_rd    <= 1'b1;
               dl_addr  <= ptr;
               ptr      <= ptr + 1'b1;
               mem_wait <= 1'b1;
               state    <= chroni_pkg::dl_read_wait;
            end
            chroni_pkg::dl_read_wait: begin
               if (mem_wait) begin
                  mem_wait <= 1'b0;
               end else if (rd_data[3:0] == chroni_pkg::dl_end_code) begin
                  dl_rd <= 1'b0;
                  ended <= 1'b1;   // held until the next frame
                  state <= chroni_pkg::dl_idle;
               end else if (rd_data[chroni_pkg::dl_lms_bit]) begin
                  dl_addr   <= ptr;
                  ptr       <= ptr + 1'b1;
                  mem_wait  <= 1'b1;
                  addr_part <= '0;
                  state     <= chroni_pkg::dl_lms_read;
               end else begin
                  dl_rd <= 1'b0;
                  state <= chroni_pkg::dl_exec;
               end
            end
            chroni_pkg::dl_lms_read: begin
               if (mem_wait) begin
                  mem_wait <= 1'b0;
               end else begin
                  case (addr_part)
                     3'd0:    text_base[7:0]  <= rd_data;
                     3'd1:    text_base[15:8] <= rd_data;
                     3'd2:    text_base[16]   <= rd_data[0];
                     3'd3:    attr_base[7:0]  <= rd_data;
                     3'd4:    attr_base[15:8] <= rd_data;
                     default: attr_base[16]   <= rd_data[0];
                  endcase
                  if (addr_part == 3'(chroni_pkg::lms_bytes - 1)) begin
                     lms_pend <= 1'b1;
                     dl_rd    <= 1'b0;
                     state    <= chroni_pkg::dl_exec;
                  end else begin
                     dl_addr   <= ptr;
                     ptr       <= ptr + 1'b1;
                     mem_wait  <= 1'b1;
                     addr_part <= addr_part + 1'b1;
                  end
               end
            end
            chroni_pkg::dl_exec: begin
               row_start  <= 1'b1;
               line_start <= 1'b1;
               lms_load   <= lms_pend;
               lms_pend   <= 1'b0;
               scan       <= '0;
               row_active <= 1'b1;
               state      <= chroni_pkg::dl_idle;
            end
            default: state <= chroni_pkg::dl_idle;
         endcase
      end
   end

   a_scanline_in_progress: assert property (@(posedge sys_clk) disable iff (rst || frame_start)
      scanline_start |-> state == chroni_pkg::dl_idle)
      else $error("scanline_start while the display list is still being read");

endmodule

/* src/chroni_text_fetch.sv */
`timescale 1ns/1ps

module chroni_text_fetch (
   input  logic                              sys_clk,
   input  logic                              rst,
   input  logic                              frame_start,
   input  logic                              row_start,
   input  logic                              line_start,
   input  logic                              lms_load,
   input  chroni_pkg::vram_addr_t            text_base,
   input  chroni_pkg::vram_addr_t            attr_base,
   input  logic [chroni_pkg::scan_w-1:0]     scan,
   input  logic [7:0]                        vram_rd_data,
   input  logic                              busy,
   output chroni_pkg::vram_addr_t            vram_rd_addr,
   output logic                              glyph_valid,
   output logic [7:0]                        glyph,
   output logic [7:0]                        attr,
   output logic [chroni_pkg::char_idx_w-1:0] char_col
);

   chroni_pkg::fetch_state_t          state;
   chroni_pkg::vram_addr_t            load_text;   // row start addresses
   chroni_pkg::vram_addr_t            load_attr;
   chroni_pkg::vram_addr_t            rd_ptr;
   logic [chroni_pkg::char_idx_w-1:0] idx;
   logic [chroni_pkg::char_idx_w-1:0] ram_addr;
   logic [1:0]                        mem_wait;
   logic                              text_we;
   logic                              attr_we;
   logic [7:0]                        ram_wr_data;
   logic [7:0]                        text_rd;
   logic [7:0]                        attr_rd;
   logic                              last_char;

   assign last_char = idx == chroni_pkg::char_idx_w'(chroni_pkg::chars_per_line - 1);

   chroni_spram #(.depth(2 ** chroni_pkg::char_idx_w), .data_t(logic [7:0])) text_ram (
      .sys_clk (sys_clk),
      .addr    (ram_addr),
      .we      (text_we),
      .wr_data (ram_wr_data),
      .rd_data (text_rd)
   );

   chroni_spram #(.depth(2 ** chroni_pkg::char_idx_w), .data_t(logic [7:0])) attr_ram (
      .sys_clk (sys_clk),
      .addr    (ram_addr),
      .we      (attr_we),
      .wr_data (ram_wr_data),
      .rd_data (attr_rd)
   );

   always_ff @(posedge sys_clk) begin
      text_we     <= 1'b0;
      attr_we     <= 1'b0;
      glyph_valid <= 1'b0;
      if (rst) begin
         state     <= chroni_pkg::fd_idle;
         load_text <= '0;
         load_attr <= '0;
      end else if (frame_start) begin
         state <= chroni_pkg::fd_idle;
      end else if (row_start) begin
         state    <= chroni_pkg::fd_text_read;
         idx      <= '0;
         mem_wait <= 2'd2;
         if (lms_load) begin
            load_text <= text_base;
            load_attr <= attr_base;
            rd_ptr    <= text_base;
         end else begin
            rd_ptr <= load_text;
         end
      end else if (line_start) begin
         state <= chroni_pkg::fd_font_read;
         idx   <= '0;
      end else begin
         case (state)
            chroni_pkg::fd_text_read, chroni_pkg::fd_attr_read: begin
               vram_rd_addr <= rd_ptr;   // one address per cycle, data 2 cycles later
               rd_ptr       <= rd_ptr + 1'b1;
               if (mem_wait != 2'd0) begin
                  mem_wait <= mem_wait - 1'b1;
               end else begin
                  ram_addr    <= idx;
                  ram_wr_data <= vram_rd_data;
                  text_we     <= state == chroni_pkg::fd_text_read;
                  attr_we     <= state == chroni_pkg::fd_attr_read;
                  idx         <= idx + 1'b1;
                  if (last_char) begin
                     idx      <= '0;
                     mem_wait <= 2'd2;
                     rd_ptr   <= load_attr;
                     state    <= state == chroni_pkg::fd_text_read ? chroni_pkg::fd_attr_read
                                                                   : chroni_pkg::fd_font_read;
                  end
               end
            end
            chroni_pkg::fd_font_read: begin
               ram_addr <= idx;
               char_col <= idx;
               mem_wait <= 2'd1;
               state    <= chroni_pkg::fd_font_fetch;
            end
            chroni_pkg::fd_font_fetch: begin
               if (mem_wait != 2'd0) begin
                  mem_wait <= mem_wait - 1'b1;
               end else begin
                  vram_rd_addr <= chroni_pkg::vram_addr_t'({text_rd, scan});  // glyph byte
                  attr         <= attr_rd;
                  mem_wait     <= 2'd1;
                  state        <= chroni_pkg::fd_font_wait;
               end
            end
            chroni_pkg::fd_font_wait: begin
               if (mem_wait != 2'd0) begin
                  mem_wait <= mem_wait - 1'b1;
               end else begin
                  glyph <= vram_rd_data;
                  state <= chroni_pkg::fd_font_write;
               end
            end
            chroni_pkg::fd_font_write: begin
               if (!busy) begin
                  glyph_valid <= 1'b1;
                  if (last_char) begin
                     state <= chroni_pkg::fd_idle;
                     if (scan == chroni_pkg::scan_w'(chroni_pkg::scan_rows - 1)) begin
                        load_text <= load_text + chroni_pkg::vram_addr_t'(chroni_pkg::chars_per_line);
                        load_attr <= load_attr + chroni_pkg::vram_addr_t'(chroni_pkg::chars_per_line);
                     end
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= chroni_pkg::fd_font_read;
                  end
               end
            end
            default: ;
         endcase
      end
   end

endmodule

/* src/chroni_pixel_out.sv */
`timescale 1ns/1ps

module chroni_pixel_out (
   input  logic                              sys_clk,
   input  logic                              rst,
   input  logic                              glyph_valid,
   input  logic [7:0]                        glyph,
   input  logic [7:0]                        attr,
   input  logic [chroni_pkg::char_idx_w-1:0] char_col,
   output logic                              busy,
   output logic                              pix_valid,
   output logic [8:0]                        pix_x,
   output logic [chroni_pkg::pal_idx_w-1:0]  pal_rd_addr,
   input  chroni_pkg::color_t                pal_rd_data,
   output chroni_pkg::color_t                pix_color
);

   logic [7:0]                                   shift;
   logic [7:0]                                   attr_q;
   logic [chroni_pkg::char_idx_w-1:0]            col;
   logic [$clog2(chroni_pkg::pixels_per_char)-1:0] bit_cnt;
   logic                                         emit;
   logic [3:0]                                   nibble;

   // free on the last pixel so the next glyph follows with one gap cycle
   assign busy        = emit && !(&bit_cnt);
   assign nibble      = shift[7] ? attr_q[3:0] : attr_q[7:4];
   assign pal_rd_addr = chroni_pkg::pal_idx_w'(nibble);
   assign pix_color   = pal_rd_data;   // palette read lines up with pix_valid

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         emit      <= 1'b0;
         bit_cnt   <= '0;
         pix_valid <= 1'b0;
      end else begin
         pix_valid <= emit;
         if (glyph_valid) begin
            emit    <= 1'b1;
            bit_cnt <= '0;
         end else if (emit) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (&bit_cnt) begin
               emit <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      pix_x <= {col, bit_cnt};
      if (glyph_valid) begin
         shift  <= glyph;
         attr_q <= attr;
         col    <= char_col;
      end else begin
         shift <= shift << 1;   // msb first
      end
   end

   a_glyph_while_busy: assert property (@(posedge sys_clk) disable iff (rst)
      glyph_valid |-> !busy)
      else $error("glyph_valid while pixel output busy");

endmodule

/* src/chroni.sv */
`timescale 1ns/1ps

module chroni (
   input  logic               sys_clk,
   input  logic               rst,
   input  logic [15:0]        cpu_addr,
   input  logic [7:0]         cpu_wr_data,
   input  logic               cpu_wr_en,
   input  logic               frame_start,
   input  logic               scanline_start,
   output logic               pix_valid,
   output logic [8:0]         pix_x,
   output chroni_pkg::color_t pix_color
);

   chroni_pkg::vram_addr_t            dl_base;
   logic                              vram_wr_en;
   chroni_pkg::vram_addr_t            vram_wr_addr;
   logic [7:0]                        vram_wr_data;
   logic                              pal_wr_en;
   logic [chroni_pkg::pal_idx_w-1:0]  pal_wr_addr;
   chroni_pkg::color_t                pal_wr_data;
   logic [chroni_pkg::pal_idx_w-1:0]  pal_rd_addr;
   logic [chroni_pkg::pal_idx_w-1:0]  pal_addr;
   chroni_pkg::color_t                pal_rd_data;
   chroni_pkg::vram_addr_t            vram_rd_addr;
   chroni_pkg::vram_addr_t            dl_addr;
   chroni_pkg::vram_addr_t            fetch_addr;
   logic [7:0]                        vram_rd_data;
   logic                              dl_rd;
   logic                              row_start;
   logic                              line_start;
   logic                              lms_load;
   chroni_pkg::vram_addr_t            text_base;
   chroni_pkg::vram_addr_t            attr_base;
   logic [chroni_pkg::scan_w-1:0]     scan;
   logic                              busy;
   logic                              glyph_valid;
   logic [7:0]                        glyph;
   logic [7:0]                        attr;
   logic [chroni_pkg::char_idx_w-1:0] char_col;

   assign vram_rd_addr = dl_rd ? dl_addr : fetch_addr;
   assign pal_addr     = pal_wr_en ? pal_wr_addr : pal_rd_addr;   // writes win

   chroni_regs regs (
      .sys_clk, .rst, .cpu_addr, .cpu_wr_data, .cpu_wr_en, .dl_base,
      .vram_wr_en, .vram_wr_addr, .vram_wr_data, .pal_wr_en, .pal_wr_addr, .pal_wr_data
   );

   chroni_vram vram (
      .sys_clk, .wr_en(vram_wr_en), .wr_addr(vram_wr_addr), .wr_data(vram_wr_data),
      .rd_addr(vram_rd_addr), .rd_data(vram_rd_data)
   );

   chroni_spram #(.depth(2 ** chroni_pkg::pal_idx_w), .data_t(chroni_pkg::color_t)) palette (
      .sys_clk, .addr(pal_addr), .we(pal_wr_en), .wr_data(pal_wr_data), .rd_data(pal_rd_data)
   );

   chroni_dlist dlist (
      .sys_clk, .rst, .frame_start, .scanline_start, .dl_base, .rd_data(vram_rd_data),
      .dl_rd, .dl_addr, .row_start, .line_start, .lms_load, .text_base, .attr_base, .scan
   );

   chroni_text_fetch text_fetch (
      .sys_clk, .rst, .frame_start, .row_start, .line_start, .lms_load, .text_base,
      .attr_base, .scan, .vram_rd_data, .busy, .vram_rd_addr(fetch_addr), .glyph_valid,
      .glyph, .attr, .char_col
   );

   chroni_pixel_out pixel_out (
      .sys_clk, .rst, .glyph_valid, .glyph, .attr, .char_col, .busy, .pix_valid, .pix_x,
      .pal_rd_addr, .pal_rd_data, .pix_color
   );

endmodule

/* sim/chroni_tb.sv */
`timescale 1ns/1ps

module chroni_tb;

   localparam int clk_period      = 8;
   localparam int line_cycles     = 600;     // scanline_start spacing
   localparam int line_pixels     = 320;
   localparam int load_writes     = 2400;    // cpu writes over the whole run, rounded up
   localparam int watchdog_cycles = 3 * 17 * line_cycles + 2 * load_writes + 2000;

   localparam chroni_pkg::vram_addr_t text_a = 17'h01000;
   localparam chroni_pkg::vram_addr_t attr_a = 17'h01800;
   localparam chroni_pkg::vram_addr_t text_b = 17'h12340;
   localparam chroni_pkg::vram_addr_t attr_b = 17'h15670;
   localparam chroni_pkg::vram_addr_t dl_a   = 17'h00900;
   localparam chroni_pkg::vram_addr_t dl_b   = 17'h00a00;

   localparam logic [7:0] ins_lms = 8'h42;   // bit 6 set, draws a row
   localparam logic [7:0] ins_row = 8'h02;
   localparam logic [7:0] ins_end = 8'h01;

   logic               sys_clk;
   logic               rst;
   logic [15:0]        cpu_addr;
   logic [7:0]         cpu_wr_data;
   logic               cpu_wr_en;
   logic               frame_start;
   logic               scanline_start;
   logic               pix_valid;
   logic [8:0]         pix_x;
   chroni_pkg::color_t pix_color;

   int                     seed;
   logic [7:0]             shadow_vram [chroni_pkg::vram_size];
   chroni_pkg::color_t     shadow_pal [16];
   chroni_pkg::vram_addr_t port_addr;
   logic [3:0]             pal_next;
   chroni_pkg::vram_addr_t cur_text;
   chroni_pkg::vram_addr_t cur_attr;
   logic [2:0]             cur_scan;
   logic                   line_visible;
   logic [8:0]             exp_x;
   logic                   expect_pixels;
   logic [7:0]             exp_code;
   logic [7:0]             exp_attr;
   logic [7:0]             exp_glyph;
   logic [3:0]             exp_index;
   chroni_pkg::color_t     exp_color;

   chroni DUT (
      .sys_clk, .rst, .cpu_addr, .cpu_wr_data, .cpu_wr_en, .frame_start, .scanline_start,
      .pix_valid, .pix_x, .pix_color
   );

   initial begin
      sys_clk = 1'b0;
      forever #(clk_period / 2) sys_clk = ~sys_clk;
   end

   // reference pixel for the next expected x
   assign expect_pixels = line_visible && exp_x < 9'(line_pixels);
   assign exp_code  = shadow_vram[cur_text + chroni_pkg::vram_addr_t'(exp_x[8:3])];
   assign exp_attr  = shadow_vram[cur_attr + chroni_pkg::vram_addr_t'(exp_x[8:3])];
   assign exp_glyph = shadow_vram[chroni_pkg::vram_addr_t'({exp_code, cur_scan})];
   assign exp_index = exp_glyph[3'd7 - exp_x[2:0]] ? exp_attr[3:0] : exp_attr[7:4];
   assign exp_color = shadow_pal[exp_index];

   always @(posedge sys_clk) begin
      if (rst || scanline_start) begin
         exp_x <= '0;
      end else if (pix_valid) begin
         exp_x <= exp_x + 9'd1;
      end
   end

   task automatic stop_failed();
      $display("TESTS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic value_error(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
      stop_failed();
   endtask

   task automatic run_error(input string what);
      $display("%0t %s", $time, what);
      stop_failed();
   endtask

   a_quiet: assert property (@(posedge sys_clk) disable iff (rst)
      !expect_pixels |-> !pix_valid)
      else value_error("pix_valid", 32'd0, 32'($sampled(pix_valid)));

   a_order: assert property (@(posedge sys_clk) disable iff (rst)
      pix_valid |-> pix_x == exp_x)
      else value_error("pix_x", 32'($sampled(exp_x)), 32'($sampled(pix_x)));

   a_color: assert property (@(posedge sys_clk) disable iff (rst)
      pix_valid |-> pix_color == exp_color)
      else value_error("pix_color", 32'($sampled(exp_color)), 32'($sampled(pix_color)));

   task automatic cpu_write(input logic [3:0] offset, input logic [7:0] data);
      @(negedge sys_clk);
      cpu_addr    = {chroni_pkg::reg_base[15:4], offset};
      cpu_wr_data = data;
      cpu_wr_en   = 1'b1;
      @(negedge sys_clk);
      cpu_wr_en = 1'b0;   // quiet cycle lets a palette pair commit
   endtask

   task automatic set_port(input chroni_pkg::vram_addr_t addr);
      cpu_write(chroni_pkg::reg_vaddr_lo, addr[7:0]);
      cpu_write(chroni_pkg::reg_vaddr_mid, addr[15:8]);
      cpu_write(chroni_pkg::reg_vaddr_hi, {7'd0, addr[16]});
      port_addr = addr;
   endtask

   task automatic put_byte(input logic [7:0] data);
      cpu_write(chroni_pkg::reg_vdata, data);
      shadow_vram[port_addr] = data;
      port_addr = port_addr + 17'd1;
   endtask

   task automatic put_color(input chroni_pkg::color_t color);
      cpu_write(chroni_pkg::reg_pal_data, color[7:0]);
      cpu_write(chroni_pkg::reg_pal_data, color[15:8]);
      shadow_pal[pal_next] = color;
      pal_next = pal_next + 4'd1;
   endtask

   task automatic fill_random(input chroni_pkg::vram_addr_t base, input int count);
      set_port(base);
      repeat (count) put_byte(8'($random(seed)));
   endtask

   task automatic write_dlist(input chroni_pkg::vram_addr_t addr,
                              input chroni_pkg::vram_addr_t text,
                              input chroni_pkg::vram_addr_t attr, input logic plain_row);
      set_port(addr);
      put_byte(ins_lms);
      put_byte(text[7:0]);
      put_byte(text[15:8]);
      put_byte({7'd0, text[16]});
      put_byte(attr[7:0]);
      put_byte(attr[15:8]);
      put_byte({7'd0, attr[16]});
      if (plain_row) begin
         put_byte(ins_row);
      end
      put_byte(ins_end);
   endtask

   task automatic set_dl_base(input chroni_pkg::vram_addr_t addr);
      cpu_write(chroni_pkg::reg_dl_lo, addr[8:1]);
      cpu_write(chroni_pkg::reg_dl_hi, addr[16:9]);
   endtask

   task automatic start_frame();
      @(negedge sys_clk);
      frame_start = 1'b1;
      @(negedge sys_clk);
      frame_start = 1'b0;
   endtask

   // one scanline, waits for all 320 pixels when the line is visible
   task automatic draw_line(input logic visible, input chroni_pkg::vram_addr_t text,
                            input chroni_pkg::vram_addr_t attr, input logic [2:0] scan);
      int cycles;
      @(negedge sys_clk);
      cur_text       = text;
      cur_attr       = attr;
      cur_scan       = scan;
      line_visible   = visible;
      scanline_start = 1'b1;
      @(negedge sys_clk);
      scanline_start = 1'b0;
      cycles = 1;
      while (visible && exp_x != 9'(line_pixels) && cycles < line_cycles) begin
         @(negedge sys_clk);
         cycles++;
      end
      if (visible && exp_x != 9'(line_pixels)) begin
         run_error("a visible line did not deliver 320 pixels within the line time");
      end else begin
         while (cycles < line_cycles) begin
            @(negedge sys_clk);
            cycles++;
         end
      end
   endtask

   task automatic play_frame(input chroni_pkg::vram_addr_t text,
                             input chroni_pkg::vram_addr_t attr, input int rows,
                             input int lines);
      int i;
      int row;
      for (i = 0; i < lines; i++) begin
         row = i / chroni_pkg::scan_rows;
         draw_line(row < rows,
                   text + chroni_pkg::vram_addr_t'(chroni_pkg::chars_per_line * row),
                   attr + chroni_pkg::vram_addr_t'(chroni_pkg::chars_per_line * row),
                   3'(i % chroni_pkg::scan_rows));
      end
   endtask

   initial begin
      seed           = 57;
      rst            = 1'b1;
      cpu_addr       = '0;
      cpu_wr_data    = '0;
      cpu_wr_en      = 1'b0;
      frame_start    = 1'b0;
      scanline_start = 1'b0;
      line_visible   = 1'b0;
      cur_text       = '0;
      cur_attr       = '0;
      cur_scan       = '0;
      port_addr      = '0;
      pal_next       = '0;
      repeat (8) @(negedge sys_clk);
      rst = 1'b0;

      cpu_write(chroni_pkg::reg_pal_index, 8'd0);
      repeat (16) put_color(chroni_pkg::color_t'($random(seed)));

      fill_random(17'h00000, 2048);   // font, 256 codes of 8 scanlines
      fill_random(text_a, 80);
      fill_random(attr_a, 80);
      fill_random(text_b, 40);
      fill_random(attr_b, 40);
      write_dlist(dl_a, text_a, attr_a, 1'b1);
      write_dlist(dl_b, text_b, attr_b, 1'b0);

      set_dl_base(dl_a);
      start_frame();
      play_frame(text_a, attr_a, 2, 17);

      // switch lists, one row then many quiet lines after the end
      set_dl_base(dl_b);
      start_frame();
      play_frame(text_b, attr_b, 1, 17);

      set_dl_base(dl_a);
      start_frame();
      play_frame(text_a, attr_a, 2, 17);

      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge sys_clk);
      $display("watchdog expired after %0d cycles, the run hung", watchdog_cycles);
      stop_failed();
   end

endmodule

/* chroni.f */
src/chroni_pkg.sv
src/chroni_regs.sv
src/chroni_vram.sv
src/chroni_spram.sv
src/chroni_dlist.sv
src/chroni_text_fetch.sv
src/chroni_pixel_out.sv
src/chroni.sv
sim/chroni_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := chroni_tb
FILELIST   := chroni.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
